//--- files.f
+incdir+src
src/pyon_pkg.sv
src/seg7_decoder.sv
src/score_countdown.sv
src/box_sequence.sv
src/game_timer.sv
src/game_fsm.sv
src/pyon_top.sv
verif/pyon_checker.sv
verif/pyon_tb.sv

//--- src/box_sequence.sv
`timescale 1ns/1ns
`include "pyon_macros.svh"

module box_sequence
  import pyon_pkg::*;
(
  input  logic clk,
  input  logic resetn,
  input  logic hit,
  output logic next_box
);

  box_pattern_t boxes;  // remaining course, nearest box in bit 0

  // --------------------------------------------------
  // course register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      boxes <= `PYON_BOX_PATTERN;  // fresh course
    end else if (hit) begin
      boxes <= boxes >> 1;  // hop one box, zeros fill in
    end
  end

  assign next_box = boxes[0];

endmodule

//--- src/game_fsm.sv
`timescale 1ns/1ns

module game_fsm
  import pyon_pkg::*;
(
  input  logic clk,
  input  logic resetn,
  input  logic start,
  input  logic key_left,
  input  logic key_right,
  input  logic next_box,     // 0 left, 1 right
  input  logic player_zero,
  input  logic pc_zero,
  output logic running,
  output logic hit,
  output logic player_won,
  output logic pc_won
);

  game_state_t state;
  logic        left_smp;     // key samples
  logic        right_smp;
  logic        left_prev;    // sample one edge earlier
  logic        right_prev;
  logic        left_rise;
  logic        right_rise;
  logic        side_ok;      // exactly the matching key rose

  // --------------------------------------------------
  // key edge detection
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      left_smp   <= 1'b0;
      right_smp  <= 1'b0;
      left_prev  <= 1'b0;
      right_prev <= 1'b0;
    end else begin
      left_smp   <= key_left;
      right_smp  <= key_right;
      left_prev  <= left_smp;
      right_prev <= right_smp;
    end
  end

  assign left_rise  = left_smp & ~left_prev;
  assign right_rise = right_smp & ~right_prev;
  assign side_ok    = next_box ? (right_rise & ~left_rise)   // both at once is no press
                               : (left_rise & ~right_rise);

  // stops the moment a score hits 00
  assign running = (state == GAME_PLAY) && !player_zero && !pc_zero;

  // --------------------------------------------------
  // game state and winner
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= GAME_IDLE;
      hit        <= 1'b0;
      player_won <= 1'b0;
      pc_won     <= 1'b0;
    end else begin
      hit <= running && side_ok;  // one cycle per press
      case (state)
        GAME_IDLE: if (start) state <= GAME_PLAY;
        GAME_PLAY: begin
          if (player_zero) begin  // player takes a tie
            state      <= GAME_OVER;
            player_won <= 1'b1;
          end else if (pc_zero) begin
            state  <= GAME_OVER;
            pc_won <= 1'b1;
          end
        end
        default: state <= GAME_OVER;  // held until reset
      endcase
    end
  end

  a_hit_in_play: assert property (@(posedge clk) disable iff (!resetn)
    hit |-> state == GAME_PLAY) else $error("hit outside GAME_PLAY");

  a_one_winner: assert property (@(posedge clk) disable iff (!resetn)
    !(player_won && pc_won)) else $error("both winner flags high");

endmodule

//--- src/game_timer.sv
`timescale 1ns/1ns
`include "pyon_macros.svh"

module game_timer
  import pyon_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       running,
  input  speed_t     speed,
  output logic       pc_step,
  output bcd_digit_t sec_lo,
  output bcd_digit_t sec_hi
);

  div_count_t sec_div;    // cycles left in this second
  div_count_t pc_div;     // cycles left to the next computer step
  div_count_t pc_reload;  // period picked by speed
  logic       sec_tick;

  function automatic div_count_t div_next(div_count_t cnt, div_count_t reload);
    return (cnt == '0) ? reload : cnt - 1'b1;  // wrap back to the period
  endfunction

  always_comb begin
    case (speed)
      2'd0:    pc_reload = div_count_t'(`PYON_PC_RELOAD_0);
      2'd1:    pc_reload = div_count_t'(`PYON_PC_RELOAD_1);
      2'd2:    pc_reload = div_count_t'(`PYON_PC_RELOAD_2);
      default: pc_reload = div_count_t'(`PYON_PC_RELOAD_3);
    endcase
  end

  // --------------------------------------------------
  // dividers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sec_div <= div_count_t'(`PYON_SEC_RELOAD);
      pc_div  <= pc_reload;
    end else if (running) begin  // paused otherwise
      sec_div <= div_next(sec_div, div_count_t'(`PYON_SEC_RELOAD));
      pc_div  <= div_next(pc_div, pc_reload);
    end
  end

  assign sec_tick = running && (sec_div == '0);
  assign pc_step  = running && (pc_div == '0);

  // --------------------------------------------------
  // seconds 00..99
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      sec_lo <= '0;
      sec_hi <= '0;
    end else if (sec_tick) begin
      if (sec_lo == bcd_digit_t'(`PYON_BCD_MAX)) begin
        sec_lo <= '0;
        sec_hi <= (sec_hi == bcd_digit_t'(`PYON_BCD_MAX)) ? '0 : sec_hi + 1'b1;  // 99 wraps
      end else begin
        sec_lo <= sec_lo + 1'b1;
      end
    end
  end

  a_sec_bcd: assert property (@(posedge clk) disable iff (!resetn)
    sec_lo <= `PYON_BCD_MAX && sec_hi <= `PYON_BCD_MAX) else $error("timer digit above 9");

endmodule

//--- src/pyon_macros.svh
`ifndef PYON_MACROS_SVH
`define PYON_MACROS_SVH

// --------------------------------------------------
// game constants
// --------------------------------------------------
`define PYON_BOX_PATTERN 32'hD15D_9689  // bit i is box i with 0 left and 1 right
`define PYON_BOX_COUNT   32             // boxes in one course
`define PYON_SCORE_TENS  3              // start score 32
`define PYON_SCORE_ONES  2
`define PYON_BCD_MAX     9              // largest decimal digit

// --------------------------------------------------
// divider reloads
// PYON_SIM 1 picks short simulation periods and 0 the 50 MHz board
// --------------------------------------------------
`define PYON_SIM 1

`define PYON_SEC_RELOAD  ((`PYON_SIM) ? 19 : 49_999_999)  // one second
`define PYON_PC_RELOAD_0 ((`PYON_SIM) ? 59 : 33_333_332)  // easy 1.5 Hz
`define PYON_PC_RELOAD_1 ((`PYON_SIM) ? 44 : 24_999_999)  // medium 2 Hz
`define PYON_PC_RELOAD_2 ((`PYON_SIM) ? 29 : 16_666_665)  // hard 3 Hz
`define PYON_PC_RELOAD_3 ((`PYON_SIM) ? 17 : 9_999_999)   // extreme 5 Hz

`endif

//--- src/pyon_pkg.sv
`include "pyon_macros.svh"

package pyon_pkg;

  // --------------------------------------------------
  // widths with a meaning
  // --------------------------------------------------
  typedef logic [3:0]  bcd_digit_t;  // one decimal digit
  typedef logic [6:0]  seg7_t;       // segments g..a, low is lit
  typedef logic [1:0]  speed_t;      // computer speed select
  typedef logic [27:0] div_count_t;  // divider counter

  typedef logic [`PYON_BOX_COUNT-1:0] box_pattern_t;  // boxes still ahead

  // --------------------------------------------------
  // game FSM
  // --------------------------------------------------
  typedef enum logic [1:0] {
    GAME_IDLE, // waiting for start
    GAME_PLAY, // race running
    GAME_OVER  // winner latched, everything frozen
  } game_state_t;

endpackage

//--- src/pyon_top.sv
`timescale 1ns/1ns

module pyon_top
  import pyon_pkg::*;
(
  input  logic   clk,
  input  logic   resetn,
  input  logic   start,
  input  logic   key_left,
  input  logic   key_right,
  input  speed_t speed,
  output seg7_t  hex_timer_lo,
  output seg7_t  hex_timer_hi,
  output seg7_t  hex_pc_lo,
  output seg7_t  hex_pc_hi,
  output seg7_t  hex_player_lo,
  output seg7_t  hex_player_hi,
  output logic   player_won,
  output logic   pc_won
);

  logic       running;     // game in play
  logic       hit;         // correct key pulse
  logic       pc_step;     // computer advances one box
  logic       next_box;    // side of the upcoming box
  logic       player_zero;
  logic       pc_zero;
  bcd_digit_t sec_lo;
  bcd_digit_t sec_hi;
  bcd_digit_t player_ones;
  bcd_digit_t player_tens;
  bcd_digit_t pc_ones;
  bcd_digit_t pc_tens;

  // --------------------------------------------------
  // control and counters
  // --------------------------------------------------
  game_fsm game_fsm_inst (
    .clk(clk), .resetn(resetn), .start(start),
    .key_left(key_left), .key_right(key_right), .next_box(next_box),
    .player_zero(player_zero), .pc_zero(pc_zero),
    .running(running), .hit(hit), .player_won(player_won), .pc_won(pc_won)
  );

  game_timer game_timer_inst (
    .clk(clk), .resetn(resetn), .running(running), .speed(speed),
    .pc_step(pc_step), .sec_lo(sec_lo), .sec_hi(sec_hi)
  );

  box_sequence box_sequence_inst (
    .clk(clk), .resetn(resetn), .hit(hit), .next_box(next_box)
  );

  score_countdown player_score_inst (  // player loses a box per hit
    .clk(clk), .resetn(resetn), .step(hit),
    .ones(player_ones), .tens(player_tens), .zero(player_zero)
  );

  score_countdown pc_score_inst (  // computer paced by divider
    .clk(clk), .resetn(resetn), .step(pc_step),
    .ones(pc_ones), .tens(pc_tens), .zero(pc_zero)
  );

  // --------------------------------------------------
  // displays
  // --------------------------------------------------
  seg7_decoder timer_lo_dec  (.digit(sec_lo),      .seg(hex_timer_lo));
  seg7_decoder timer_hi_dec  (.digit(sec_hi),      .seg(hex_timer_hi));
  seg7_decoder pc_lo_dec     (.digit(pc_ones),     .seg(hex_pc_lo));
  seg7_decoder pc_hi_dec     (.digit(pc_tens),     .seg(hex_pc_hi));
  seg7_decoder player_lo_dec (.digit(player_ones), .seg(hex_player_lo));
  seg7_decoder player_hi_dec (.digit(player_tens), .seg(hex_player_hi));

endmodule

//--- src/score_countdown.sv
`timescale 1ns/1ns
`include "pyon_macros.svh"

module score_countdown
  import pyon_pkg::*;
(
  input  logic       clk,
  input  logic       resetn,
  input  logic       step,   // one box done
  output bcd_digit_t ones,
  output bcd_digit_t tens,
  output logic       zero    // course finished
);

  assign zero = (ones == '0) && (tens == '0);

  // --------------------------------------------------
  // BCD down counter, sticks at 00
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tens <= bcd_digit_t'(`PYON_SCORE_TENS);
      ones <= bcd_digit_t'(`PYON_SCORE_ONES);
    end else if (step && !zero) begin
      if (ones == '0) begin  // borrow
        ones <= bcd_digit_t'(`PYON_BCD_MAX);
        tens <= tens - 1'b1;
      end else begin
        ones <= ones - 1'b1;
      end
    end
  end

  a_score_bcd: assert property (@(posedge clk) disable iff (!resetn)
    ones <= `PYON_BCD_MAX && tens <= `PYON_BCD_MAX) else $error("score digit above 9");

endmodule

//--- src/seg7_decoder.sv
`timescale 1ns/1ns

module seg7_decoder
  import pyon_pkg::*;
(
  input  bcd_digit_t digit,
  output seg7_t      seg    // gfedcba, low lights
);

  // --------------------------------------------------
  // digit table
  // --------------------------------------------------
  always_comb begin
    case (digit)
      4'd0:    seg = 7'b100_0000;
      4'd1:    seg = 7'b111_1001;
      4'd2:    seg = 7'b010_0100;
      4'd3:    seg = 7'b011_0000;
      4'd4:    seg = 7'b001_1001;
      4'd5:    seg = 7'b001_0010;
      4'd6:    seg = 7'b000_0010;
      4'd7:    seg = 7'b111_1000;
      4'd8:    seg = 7'b000_0000;
      4'd9:    seg = 7'b001_0000;
      default: seg = 7'b100_0000;  // non-decimal shows 0
    endcase
  end

endmodule

//--- verif/pyon_checker.sv
`timescale 1ns/1ns
`include "pyon_macros.svh"

module pyon_checker
  import pyon_pkg::*;
(
  input  logic  clk,
  input  logic  resetn,
  input  logic  start,
  input  logic  key_left,
  input  logic  key_right,
  input  seg7_t hex_timer_lo,
  input  seg7_t hex_timer_hi,
  input  seg7_t hex_pc_lo,
  input  seg7_t hex_pc_hi,
  input  seg7_t hex_player_lo,
  input  seg7_t hex_player_hi,
  input  logic  player_won,
  input  logic  pc_won,
  output int    mismatch_count,
  output int    other_count
);

  localparam int START_SCORE = 10 * `PYON_SCORE_TENS + `PYON_SCORE_ONES;
  // segment codes of 9 down to 0, gfedcba, low lights
  localparam logic [69:0] SEG_TABLE = {7'h10, 7'h00, 7'h78, 7'h02, 7'h12,
                                       7'h19, 7'h30, 7'h24, 7'h79, 7'h40};

  int         box_index;                    // next box the player must hop
  int         exp_player;                   // player score the DUT should show
  int         prev_timer, prev_pc;          // displays one cycle earlier
  int         timer_now, pc_now, player_now;
  logic       in_play, run_prev, run_now;   // DUT running, one cycle apart
  logic       left_smp, left_prev, right_smp, right_prev, left_rise, right_rise;
  logic [1:0] hit_pipe;                     // press to score change is two edges
  logic       exp_player_won, exp_pc_won;

  function automatic logic expected_side(int index);
    logic [`PYON_BOX_COUNT-1:0] pattern;
    pattern = `PYON_BOX_PATTERN;
    return pattern[index];  // 1 is right
  endfunction

  function automatic int seg_digit(seg7_t seg);
    int d;
    for (d = 0; d < 10; d++)
      if (SEG_TABLE[7*d +: 7] == seg) return d;
    return -1;  // not a digit
  endfunction

  task automatic read_pair(input seg7_t hi, input seg7_t lo, input string name, output int val);
    val = 10 * seg_digit(hi) + seg_digit(lo);
    if (seg_digit(hi) < 0 || seg_digit(lo) < 0) begin
      $display("%0t: %s display shows a segment pattern that is no digit", $time, name);
      other_count++;
    end
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected != actual) begin
      $display("ERR %0t %s expected %0d actual %0d", $time, name, expected, actual);
      mismatch_count++;
    end
  endtask

  initial begin
    mismatch_count = 0;
    other_count    = 0;
  end

  // --------------------------------------------------
  // once per edge, on the values of the cycle just ended
  // --------------------------------------------------
  always @(posedge clk) begin
    if (!resetn) begin
      {in_play, run_prev, exp_player_won, exp_pc_won} = '0;
      {left_smp, left_prev, right_smp, right_prev}    = '0;
      hit_pipe   = '0;
      box_index  = 0;
      exp_player = START_SCORE;
      prev_timer = 0;            // reset values act as the first reference
      prev_pc    = START_SCORE;
    end else begin
      read_pair(hex_timer_hi, hex_timer_lo, "timer", timer_now);
      read_pair(hex_pc_hi, hex_pc_lo, "pc score", pc_now);
      read_pair(hex_player_hi, hex_player_lo, "player score", player_now);
      if (timer_now != prev_timer)  // one second up, only while running
        check_value("timer", run_prev ? (prev_timer + 1) % 100 : prev_timer, timer_now);
      if (pc_now != prev_pc)        // one box down, only while running
        check_value("pc score", run_prev ? prev_pc - 1 : prev_pc, pc_now);
      if (hit_pipe[1]) exp_player--;
      check_value("player score", exp_player, player_now);
      check_value("player_won", exp_player_won, player_won);
      check_value("pc_won", exp_pc_won, pc_won);
      if (in_play && !exp_player_won && !exp_pc_won && (player_now == 0 || pc_now == 0)) begin
        exp_player_won = (player_now == 0);  // player takes a tie
        exp_pc_won     = (player_now != 0);
      end
      run_now    = in_play && player_now != 0 && pc_now != 0;
      left_rise  = left_smp && !left_prev;
      right_rise = right_smp && !right_prev;
      hit_pipe   = {hit_pipe[0], 1'b0};
      if (run_now && (left_rise != right_rise) && right_rise == expected_side(box_index)) begin
        hit_pipe[0] = 1'b1;  // lone rise on the matching side
        box_index++;
      end
      {left_prev, right_prev} = {left_smp, right_smp};
      {left_smp, right_smp}   = {key_left, key_right};
      in_play    = in_play || start;  // start only counts while idle
      run_prev   = run_now;
      prev_timer = timer_now;
      prev_pc    = pc_now;
    end
  end

endmodule

//--- verif/pyon_tb.sv
`timescale 1ns/1ns
`include "pyon_macros.svh"

module pyon_tb
  import pyon_pkg::*;
();

  logic   clk;
  logic   resetn;
  logic   start;
  logic   key_left;
  logic   key_right;
  speed_t speed;
  seg7_t  hex_timer_lo, hex_timer_hi, hex_pc_lo, hex_pc_hi, hex_player_lo, hex_player_hi;
  logic   player_won, pc_won;
  int     mismatch_count, other_count;
  int     timeout_count;
  integer seed;
  int     box_index;                                     // hops done by this run
  logic [`PYON_BOX_COUNT-1:0] pattern = `PYON_BOX_PATTERN;

  pyon_top pyon_top_inst (
    .clk(clk), .resetn(resetn), .start(start), .key_left(key_left),
    .key_right(key_right), .speed(speed), .hex_timer_lo(hex_timer_lo),
    .hex_timer_hi(hex_timer_hi), .hex_pc_lo(hex_pc_lo), .hex_pc_hi(hex_pc_hi),
    .hex_player_lo(hex_player_lo), .hex_player_hi(hex_player_hi),
    .player_won(player_won), .pc_won(pc_won)
  );

  pyon_checker pyon_checker_inst (
    .clk(clk), .resetn(resetn), .start(start), .key_left(key_left),
    .key_right(key_right), .hex_timer_lo(hex_timer_lo), .hex_timer_hi(hex_timer_hi),
    .hex_pc_lo(hex_pc_lo), .hex_pc_hi(hex_pc_hi), .hex_player_lo(hex_player_lo),
    .hex_player_hi(hex_player_hi), .player_won(player_won), .pc_won(pc_won),
    .mismatch_count(mismatch_count), .other_count(other_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 100 MHz
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic apply_reset(input speed_t spd);
    @(posedge clk);
    resetn <= 1'b0;
    speed  <= spd;  // reload picked up during reset
    box_index = 0;
    idle_cycles(3);
    resetn <= 1'b1;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  // hold for two cycles, then a random gap
  task automatic press(input logic right, input logic both);
    @(posedge clk);
    key_left  <= !right || both;
    key_right <= right || both;
    idle_cycles(2);
    key_left  <= 1'b0;
    key_right <= 1'b0;
    idle_cycles(2 + ($random(seed) & 7));
  endtask

  task automatic hop_correct();
    seg7_t lo_was;
    int    n;
    lo_was = hex_player_lo;  // ones digit moves on every hop
    press(pattern[box_index], 1'b0);
    for (n = 0; n < 20 && hex_player_lo == lo_was; n++) @(posedge clk);
    if (hex_player_lo == lo_was) begin
      $display("%0t: timeout, player score did not move after a correct key press", $time);
      timeout_count++;
    end
    box_index++;
  endtask

  task automatic wait_winner(input int limit);
    int n;
    for (n = 0; n < limit && !player_won && !pc_won; n++) @(posedge clk);
    if (!player_won && !pc_won) begin
      $display("%0t: timeout, no winner flag rose", $time);
      timeout_count++;
    end
  endtask

  initial begin
    seed          = 32'h90ac;
    resetn        = 1'b0;
    start         = 1'b0;
    key_left      = 1'b0;
    key_right     = 1'b0;
    speed         = '0;
    timeout_count = 0;
    box_index     = 0;
    // --------------------------------------------------
    // player race at the easy speed
    // --------------------------------------------------
    apply_reset(2'd0);
    press(1'b0, 1'b0);  // idle, keys ignored
    press(1'b1, 1'b1);
    idle_cycles(25);    // timer stays at 00
    pulse_start();
    idle_cycles(5);
    press(!pattern[0], 1'b0);  // wrong side
    press(1'b0, 1'b1);         // both keys
    repeat (`PYON_BOX_COUNT) hop_correct();
    wait_winner(10);
    press(1'b0, 1'b0);  // frozen after game over
    press(1'b1, 1'b0);
    idle_cycles(40);
    // --------------------------------------------------
    // computer alone at extreme speed
    // --------------------------------------------------
    apply_reset(2'd3);
    pulse_start();
    wait_winner(2000);
    press(pattern[0], 1'b0);
    idle_cycles(60);
    $display("closing: %0d value mismatches, %0d other failures, %0d timeouts",
             mismatch_count, other_count, timeout_count);
    if (mismatch_count + other_count + timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
